//--- project.f
rtl/dphy_rx_pkg.sv
rtl/lp_entry_detect.sv
rtl/lane_hs_capture.sv
rtl/lane_byte_merge.sv
rtl/dphy_rx_frontend.sv
bench/frontend_checker.sv
bench/tb_dphy_rx_frontend.sv

//--- Bender.yml
package:
  name: dphy_rx_frontend

sources:
  # rtl, package first
  - rtl/dphy_rx_pkg.sv
  - rtl/lp_entry_detect.sv
  - rtl/lane_hs_capture.sv
  - rtl/lane_byte_merge.sv
  - rtl/dphy_rx_frontend.sv

  # testbench
  - target: test
    files:
      - bench/frontend_checker.sv
      - bench/tb_dphy_rx_frontend.sv

//--- bench/tb_dphy_rx_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dphy_rx_frontend;

    import dphy_rx_pkg::*;

    localparam int NUM_LANES    = 2;
    localparam int HEARTBEAT_W  = 6;    // msb toggles every 32 cycles
    localparam int CLK_HALF     = 5;    // 10 ns period
    localparam int RESET_CYCLES = 2;
    localparam int TAIL_CYCLES  = 20;   // slack past the end of the table

    // --------------------------------------------------
    //  dut and checker signals
    // --------------------------------------------------

    logic                                   mipi0_dphy_rx_clk = 1'b0;
    logic                                   reset;
    lp_state_e  [NUM_LANES-1:0]             lp;
    logic   [NUM_LANES-1:0][HS_WORD_W-1:0]  hs_word;
    logic   [NUM_LANES-1:0]                 hs_valid;

    logic   [NUM_LANES-1:0]                 hs_odt_en;
    logic                                   drst_n;
    logic                                   byte_ready;
    logic   [NUM_LANES-1:0][BYTE_W-1:0]     byte_data;
    logic                                   heartbeat;

    logic                                   check_en;
    logic   [NUM_LANES-1:0]                 exp_odt_en;
    logic                                   exp_drst_n;
    logic                                   exp_ready;
    logic   [NUM_LANES-1:0][BYTE_W-1:0]     exp_data;
    logic                                   done;
    int                                     error_count;
    int                                     check_count;

    // one row per cycle with the values expected at its rising edge
    typedef struct packed {
        logic   [1:0]               lp0;
        logic   [1:0]               lp1;
        logic   [NUM_LANES-1:0]     valid;      // {lane 1, lane 0}
        logic   [NUM_LANES-1:0]     odt_en;
        logic                       drst_n;
        logic                       ready;
    } row_t;

    row_t                                   rows_q[$];
    logic   [NUM_LANES-1:0][HS_WORD_W-1:0]  words_q[$];
    integer                                 seed = 26;
    int                                     cycle_count = 0;
    int                                     cycle_limit = 0;

    always #CLK_HALF mipi0_dphy_rx_clk = ~mipi0_dphy_rx_clk;

    dphy_rx_frontend
            #(
                .NUM_LANES          (NUM_LANES          ),
                .HEARTBEAT_W        (HEARTBEAT_W        )
            )
        i_dut
            (
                .mipi0_dphy_rx_clk  (mipi0_dphy_rx_clk  ),
                .reset              (reset              ),
                .lp_i               (lp                 ),
                .hs_word_i          (hs_word            ),
                .hs_valid_i         (hs_valid           ),
                .hs_odt_en_o        (hs_odt_en          ),
                .drst_n_o           (drst_n             ),
                .byte_ready_o       (byte_ready         ),
                .byte_data_o        (byte_data          ),
                .heartbeat_o        (heartbeat          )
            );

    frontend_checker
            #(
                .NUM_LANES          (NUM_LANES          ),
                .HB_HALF            (2 ** (HEARTBEAT_W - 1))
            )
        i_checker
            (
                .mipi0_dphy_rx_clk  (mipi0_dphy_rx_clk  ),
                .reset              (reset              ),
                .check_en_i         (check_en           ),
                .done_i             (done               ),
                .hs_odt_en_i        (hs_odt_en          ),
                .drst_n_i           (drst_n             ),
                .byte_ready_i       (byte_ready         ),
                .byte_data_i        (byte_data          ),
                .heartbeat_i        (heartbeat          ),
                .exp_odt_en_i       (exp_odt_en         ),
                .exp_drst_n_i       (exp_drst_n         ),
                .exp_ready_i        (exp_ready          ),
                .exp_data_i         (exp_data           ),
                .error_count_o      (error_count        ),
                .check_count_o      (check_count        )
            );

    // --------------------------------------------------
    //  stimulus table
    // --------------------------------------------------

    task automatic add_rows(input int count, input lp_state_e lp0, input lp_state_e lp1,
                            input logic [1:0] valid, input logic [1:0] odt_en,
                            input logic drst_n_exp, input logic ready);
        row_t row;
        row.lp0    = lp0;
        row.lp1    = lp1;
        row.valid  = valid;
        row.odt_en = odt_en;
        row.drst_n = drst_n_exp;
        row.ready  = ready;
        repeat (count) rows_q.push_back(row);
    endtask

    task automatic build_table();
        logic [31:0] rnd;
        //        n   lp0   lp1   valid  odt_en drst  ready
        add_rows( 4, LP11, LP11, 2'b00, 2'b00, 1'b1, 1'b0);    // idle in stop
        add_rows( 1, LP01, LP01, 2'b00, 2'b00, 1'b1, 1'b0);    // hs request
        add_rows( 1, LP00, LP01, 2'b00, 2'b00, 1'b1, 1'b0);    // lane 1 lags
        add_rows( 1, LP00, LP01, 2'b00, 2'b01, 1'b1, 1'b0);    // only lane 0 terminated
        add_rows( 1, LP00, LP00, 2'b00, 2'b11, 1'b0, 1'b0);    // data reset pulse
        add_rows( 1, LP00, LP00, 2'b00, 2'b11, 1'b1, 1'b0);
        add_rows( 2, LP00, LP00, 2'b11, 2'b11, 1'b1, 1'b0);    // rows 9 and 10
        add_rows( 2, LP00, LP00, 2'b11, 2'b11, 1'b1, 1'b1);
        add_rows( 1, LP00, LP00, 2'b01, 2'b11, 1'b1, 1'b1);    // lane 0 valid alone
        add_rows( 1, LP00, LP00, 2'b10, 2'b11, 1'b1, 1'b1);    // lane 1 valid alone
        add_rows( 1, LP00, LP00, 2'b11, 2'b11, 1'b1, 1'b0);    // row 15 is the last terminated
        add_rows( 1, LP11, LP11, 2'b00, 2'b00, 1'b1, 1'b0);
        add_rows( 1, LP11, LP11, 2'b00, 2'b00, 1'b1, 1'b1);
        add_rows( 2, LP11, LP11, 2'b00, 2'b00, 1'b1, 1'b0);
        add_rows( 1, LP11, LP11, 2'b11, 2'b00, 1'b1, 1'b0);    // row 20 inside settle
        add_rows( 1, LP11, LP11, 2'b00, 2'b00, 1'b1, 1'b0);
        add_rows( 1, LP11, LP11, 2'b00, 2'b00, 1'b1, 1'b1);
        add_rows( 3, LP11, LP11, 2'b00, 2'b00, 1'b1, 1'b0);
        add_rows( 2, LP11, LP11, 2'b11, 2'b00, 1'b1, 1'b0);    // window closes after row 26
        add_rows( 1, LP11, LP11, 2'b11, 2'b00, 1'b1, 1'b1);
        add_rows( 2, LP11, LP11, 2'b00, 2'b00, 1'b1, 1'b0);
        add_rows( 1, LP01, LP01, 2'b00, 2'b00, 1'b1, 1'b0);    // request again
        add_rows( 1, LP10, LP10, 2'b00, 2'b00, 1'b1, 1'b0);    // escape drops the arm
        add_rows( 1, LP11, LP11, 2'b00, 2'b00, 1'b1, 1'b0);
        add_rows( 4, LP00, LP00, 2'b11, 2'b00, 1'b1, 1'b0);    // bridge without arm
        add_rows(32, LP11, LP11, 2'b00, 2'b00, 1'b1, 1'b0);    // idle past second toggle
        for (int r = 0; r < rows_q.size(); r++) begin
            rnd = $random(seed);
            words_q.push_back(rnd[NUM_LANES*HS_WORD_W-1:0]);
        end
    endtask

    task automatic apply_row(input int r);
        row_t                                   row;
        logic   [NUM_LANES-1:0][HS_WORD_W-1:0]  old_word;
        int                                     i;
        row        = rows_q[r];
        lp[0]      = lp_state_e'(row.lp0);
        lp[1]      = lp_state_e'(row.lp1);
        hs_word    = words_q[r];
        hs_valid   = row.valid;
        exp_odt_en = row.odt_en;
        exp_drst_n = row.drst_n;
        exp_ready  = row.ready;
        old_word   = (r >= 2) ? words_q[r-2] : '0;     // two register stages to byte_data_o
        for (i = 0; i < NUM_LANES; i++) begin
            exp_data[i] = old_word[i][BYTE_W-1:0];
        end
        check_en   = 1'b1;
    endtask

    task automatic finish_run(input logic timed_out);
        logic all_checked;
        done = 1'b1;    // checker prints its counts
        #1;
        all_checked = (check_count == rows_q.size());
        if (!timed_out && !all_checked) begin
            $display("only %0d of %0d table rows were checked", check_count, rows_q.size());
        end
        if (timed_out || error_count != 0 || !all_checked) begin
            $display("Some tests failed");
        end
        else begin
            $display("All tests passed");
        end
        $finish;
    endtask

    // --------------------------------------------------
    //  reset, driving loop and timeout
    // --------------------------------------------------

    initial begin
        reset      = 1'b1;
        lp[0]      = LP11;
        lp[1]      = LP11;
        hs_word    = '0;
        hs_valid   = '0;
        check_en   = 1'b0;
        exp_odt_en = '0;
        exp_drst_n = 1'b1;
        exp_ready  = 1'b0;
        exp_data   = '0;
        done       = 1'b0;
        build_table();
        cycle_limit = rows_q.size() + RESET_CYCLES + TAIL_CYCLES;
        repeat (RESET_CYCLES) @(posedge mipi0_dphy_rx_clk);
        @(negedge mipi0_dphy_rx_clk);
        reset = 1'b0;
        for (int r = 0; r < rows_q.size(); r++) begin
            apply_row(r);
            @(negedge mipi0_dphy_rx_clk);
        end
        check_en = 1'b0;
        finish_run(1'b0);
    end

    always @(posedge mipi0_dphy_rx_clk) begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("timeout: stimulus table not finished after %0d cycles", cycle_limit);
            finish_run(1'b1);
        end
    end

endmodule

`default_nettype wire

//--- bench/frontend_checker.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_checker
        #(
            parameter int   NUM_LANES   = 2     ,
            parameter int   HB_HALF     = 32        // cycles between heartbeat edges
        )
        (
            input   var logic                                       mipi0_dphy_rx_clk   ,
            input   var logic                                       reset               ,
            input   var logic                                       check_en_i          ,
            input   var logic                                       done_i              ,

            // dut outputs
            input   var logic   [NUM_LANES-1:0]                     hs_odt_en_i         ,
            input   var logic                                       drst_n_i            ,
            input   var logic                                       byte_ready_i        ,
            input   var logic   [NUM_LANES-1:0][dphy_rx_pkg::BYTE_W-1:0] byte_data_i    ,
            input   var logic                                       heartbeat_i         ,

            // expected values of the current row
            input   var logic   [NUM_LANES-1:0]                     exp_odt_en_i        ,
            input   var logic                                       exp_drst_n_i        ,
            input   var logic                                       exp_ready_i         ,
            input   var logic   [NUM_LANES-1:0][dphy_rx_pkg::BYTE_W-1:0] exp_data_i     ,

            output  var int                                         error_count_o       ,
            output  var int                                         check_count_o
        );

    int     errors   = 0;
    int     checks   = 0;
    int     hb_edges = 0;   // rising edges since reset release
    logic   exp_heartbeat;

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, want);
        errors++;
    endtask

    // --------------------------------------------------
    //  per cycle compare
    // --------------------------------------------------

    always @(posedge mipi0_dphy_rx_clk) begin
        if (check_en_i) begin
            checks++;
            exp_heartbeat = ((hb_edges / HB_HALF) % 2) != 0;
            if (hs_odt_en_i !== exp_odt_en_i)
                report_mismatch("hs_odt_en_o", hs_odt_en_i, exp_odt_en_i);
            if (drst_n_i !== exp_drst_n_i)
                report_mismatch("drst_n_o", drst_n_i, exp_drst_n_i);
            if (byte_ready_i !== exp_ready_i)
                report_mismatch("byte_ready_o", byte_ready_i, exp_ready_i);
            if (exp_ready_i && (byte_data_i !== exp_data_i))
                report_mismatch("byte_data_o", byte_data_i, exp_data_i);    // only with a strobe
            if (heartbeat_i !== exp_heartbeat)
                report_mismatch("heartbeat_o", heartbeat_i, exp_heartbeat);
        end
        if (!reset) begin
            hb_edges++;
        end
    end

    always @(posedge done_i) begin
        $display("frontend_checker: %0d cycles checked, %0d errors", checks, errors);
    end

    assign error_count_o = errors;
    assign check_count_o = checks;

endmodule

`default_nettype wire

//--- rtl/dphy_rx_frontend.sv
`timescale 1ns/1ps
`default_nettype none

module dphy_rx_frontend
        #(
            parameter int   NUM_LANES   = dphy_rx_pkg::NUM_LANES_DEFAULT    ,
            parameter int   HEARTBEAT_W = dphy_rx_pkg::HEARTBEAT_W_DEFAULT
        )
        (
            input   var logic                                       mipi0_dphy_rx_clk   ,
            input   var logic                                       reset               ,

            // from the d-phy hard macro
            input   var dphy_rx_pkg::lp_state_e [NUM_LANES-1:0]     lp_i                ,
            input   var logic   [NUM_LANES-1:0][dphy_rx_pkg::HS_WORD_W-1:0] hs_word_i   ,
            input   var logic   [NUM_LANES-1:0]                     hs_valid_i          ,

            // back to the d-phy hard macro
            output  var logic   [NUM_LANES-1:0]                     hs_odt_en_o         ,
            output  var logic                                       drst_n_o            ,

            // to the csi-2 decoder
            output  var logic                                       byte_ready_o        ,
            output  var logic   [NUM_LANES-1:0][dphy_rx_pkg::BYTE_W-1:0] byte_data_o    ,

            output  var logic                                       heartbeat_o
        );

    import dphy_rx_pkg::*;

    // --------------------------------------------------
    //  lp entry detection on lane 0
    // --------------------------------------------------

    logic   odt_arm;

    lp_entry_detect
        u_lp_entry_detect
            (
                .mipi0_dphy_rx_clk  (mipi0_dphy_rx_clk  ),
                .reset              (reset              ),
                .lp0_i              (lp_i[0]            ),
                .odt_arm_o          (odt_arm            ),
                .drst_n_o           (drst_n_o           )
            );

    // --------------------------------------------------
    //  per lane receivers
    // --------------------------------------------------

    logic   [NUM_LANES-1:0]                 lane_valid;
    logic   [NUM_LANES-1:0][BYTE_W-1:0]     lane_byte;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        lane_hs_capture
            u_lane_hs_capture
                (
                    .mipi0_dphy_rx_clk  (mipi0_dphy_rx_clk  ),
                    .reset              (reset              ),
                    .lp_i               (lp_i[i]            ),
                    .odt_arm_i          (odt_arm            ),  // same arm for every lane
                    .hs_word_i          (hs_word_i[i]       ),
                    .hs_valid_i         (hs_valid_i[i]      ),
                    .hs_odt_en_o        (hs_odt_en_o[i]     ),
                    .lane_valid_o       (lane_valid[i]      ),
                    .lane_byte_o        (lane_byte[i]       )
                );
    end

    // --------------------------------------------------
    //  lane merge and heartbeat
    // --------------------------------------------------

    lane_byte_merge
            #(
                .NUM_LANES          (NUM_LANES          ),
                .HEARTBEAT_W        (HEARTBEAT_W        )
            )
        u_lane_byte_merge
            (
                .mipi0_dphy_rx_clk  (mipi0_dphy_rx_clk  ),
                .reset              (reset              ),
                .lane_valid_i       (lane_valid         ),
                .lane_byte_i        (lane_byte          ),
                .byte_ready_o       (byte_ready_o       ),
                .byte_data_o        (byte_data_o        ),
                .heartbeat_o        (heartbeat_o        )
            );

endmodule

`default_nettype wire

//--- rtl/lane_byte_merge.sv
`timescale 1ns/1ps
`default_nettype none

module lane_byte_merge
        #(
            parameter int   NUM_LANES   = dphy_rx_pkg::NUM_LANES_DEFAULT    ,
            parameter int   HEARTBEAT_W = dphy_rx_pkg::HEARTBEAT_W_DEFAULT
        )
        (
            input   var logic                                       mipi0_dphy_rx_clk   ,
            input   var logic                                       reset               ,

            input   var logic   [NUM_LANES-1:0]                     lane_valid_i        ,
            input   var logic   [NUM_LANES-1:0][dphy_rx_pkg::BYTE_W-1:0] lane_byte_i    ,

            output  var logic                                       byte_ready_o        ,
            output  var logic   [NUM_LANES-1:0][dphy_rx_pkg::BYTE_W-1:0] byte_data_o    ,
            output  var logic                                       heartbeat_o
        );

    // --------------------------------------------------
    //  lane alignment
    // --------------------------------------------------

    logic   all_valid;

    // every lane must deliver in the same cycle
    assign all_valid = &lane_valid_i;

    always_ff @(posedge mipi0_dphy_rx_clk or posedge reset) begin
        if (reset) begin
            byte_ready_o <= 1'b0;
        end
        else begin
            byte_ready_o <= all_valid;      // plain strobe, no back pressure
        end
    end

    always_ff @(posedge mipi0_dphy_rx_clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            byte_data_o[i] <= lane_byte_i[i];   // lane 0 in the low slot
        end
    end

    // --------------------------------------------------
    //  heartbeat
    // --------------------------------------------------

    logic   [HEARTBEAT_W-1:0]   hb_cnt;

    always_ff @(posedge mipi0_dphy_rx_clk or posedge reset) begin
        if (reset) begin
            hb_cnt <= '0;
        end
        else begin
            hb_cnt <= hb_cnt + 1'b1;        // free running, wraps
        end
    end

    // msb flips every 2**(HEARTBEAT_W-1) cycles
    assign heartbeat_o = hb_cnt[HEARTBEAT_W-1];

endmodule

`default_nettype wire

//--- rtl/lane_hs_capture.sv
`timescale 1ns/1ps
`default_nettype none

module lane_hs_capture
        (
            input   var logic                               mipi0_dphy_rx_clk   ,
            input   var logic                               reset               ,

            input   var dphy_rx_pkg::lp_state_e             lp_i                ,   // this lane
            input   var logic                               odt_arm_i           ,
            input   var logic   [dphy_rx_pkg::HS_WORD_W-1:0] hs_word_i          ,
            input   var logic                               hs_valid_i          ,

            output  var logic                               hs_odt_en_o         ,
            output  var logic                               lane_valid_o        ,
            output  var logic   [dphy_rx_pkg::BYTE_W-1:0]   lane_byte_o
        );

    import dphy_rx_pkg::*;

    // --------------------------------------------------
    //  termination enable
    // --------------------------------------------------

    // follows the lane's own bridge state, not lane 0's
    assign hs_odt_en_o = (lp_i == LP00) && odt_arm_i;

    // --------------------------------------------------
    //  settle countdown and window
    // --------------------------------------------------

    logic   [SETTLE_CNT_W-1:0]  settle_cnt;
    logic                       hs_window;

    always_ff @(posedge mipi0_dphy_rx_clk or posedge reset) begin
        if (reset) begin
            settle_cnt <= '0;
            hs_window  <= 1'b0;
        end
        else begin
            if (hs_odt_en_o) begin
                settle_cnt <= HS_SETTLE_CYCLES;         // reload while terminated
            end
            else if (settle_cnt != '0) begin
                settle_cnt <= settle_cnt - 1'b1;
            end

            hs_window <= (settle_cnt != '0);
        end
    end

    // --------------------------------------------------
    //  byte capture
    // --------------------------------------------------

    always_ff @(posedge mipi0_dphy_rx_clk or posedge reset) begin
        if (reset) begin
            lane_valid_o <= 1'b0;
        end
        else begin
            lane_valid_o <= hs_window && hs_valid_i;    // qualified by the window
        end
    end

    always_ff @(posedge mipi0_dphy_rx_clk) begin
        lane_byte_o <= hs_word_i[BYTE_W-1:0];           // low byte only, 8 bit mode
    end

endmodule

`default_nettype wire

//--- rtl/lp_entry_detect.sv
`timescale 1ns/1ps
`default_nettype none

module lp_entry_detect
        (
            input   var logic                       mipi0_dphy_rx_clk   ,
            input   var logic                       reset               ,

            input   var dphy_rx_pkg::lp_state_e     lp0_i               ,   // lane 0 {p,n}

            output  var logic                       odt_arm_o           ,   // shared by all lanes
            output  var logic                       drst_n_o                // phy data path reset
        );

    import dphy_rx_pkg::*;

    // --------------------------------------------------
    //  two stage lp sampler
    // --------------------------------------------------

    lp_state_e  lp_s1;      // newer sample
    lp_state_e  lp_s2;      // older sample

    always_ff @(posedge mipi0_dphy_rx_clk or posedge reset) begin
        if (reset) begin
            lp_s1 <= LP11;  // start from stop, no false edges
            lp_s2 <= LP11;
        end
        else begin
            lp_s1 <= lp0_i;
            lp_s2 <= lp_s1;
        end
    end

    // --------------------------------------------------
    //  transition decode (older, newer)
    // --------------------------------------------------

    logic   from3to1;
    logic   from1to0;
    logic   from1to2;
    logic   from1to3;
    logic   fromxto3;
    logic   from1tox;

    always_comb begin
        from3to1 = (lp_s2 == LP11) && (lp_s1 == LP01);    // stop -> hs request
        from1to0 = (lp_s2 == LP01) && (lp_s1 == LP00);    // request -> bridge
        from1to2 = (lp_s2 == LP01) && (lp_s1 == LP10);    // request -> escape
        from1to3 = (lp_s2 == LP01) && (lp_s1 == LP11);    // request aborted
        fromxto3 = (lp_s2 != LP11) && (lp_s1 == LP11);    // any return to stop
        from1tox = (lp_s2 == LP01) && (lp_s1 != LP01);    // leaving request
    end

    // --------------------------------------------------
    //  entry flags
    // --------------------------------------------------

    logic   odt_arm;
    logic   hs_armed;

    always_ff @(posedge mipi0_dphy_rx_clk or posedge reset) begin
        if (reset) begin
            odt_arm  <= 1'b0;
            hs_armed <= 1'b0;
            drst_n_o <= 1'b1;
        end
        else begin
            // termination arm, dropped on escape or stop
            if (!odt_arm) begin
                odt_arm <= from3to1;
            end
            else if (from1to2 || from1to3 || fromxto3) begin
                odt_arm <= 1'b0;
            end

            // only valid while sitting in hs request
            if (!hs_armed) begin
                hs_armed <= from3to1;
            end
            else if (from1tox) begin
                hs_armed <= 1'b0;
            end

            drst_n_o <= !(hs_armed && from1to0);    // one cycle low at bridge entry
        end
    end

    assign odt_arm_o = odt_arm;

endmodule

`default_nettype wire

//--- rtl/dphy_rx_pkg.sv
`default_nettype none

package dphy_rx_pkg;

    // --------------------------------------------------
    //  lp line pair {p,n} as seen on di_lprx
    // --------------------------------------------------

    typedef enum logic [1:0] {
        LP00 = 2'b00,   // bridge
        LP01 = 2'b01,   // hs request
        LP10 = 2'b10,   // escape request
        LP11 = 2'b11    // stop
    } lp_state_e;

    // --------------------------------------------------
    //  data widths
    // --------------------------------------------------

    localparam int HS_WORD_W = 16;     // phy hs word per lane
    localparam int BYTE_W    = 8;      // byte handed to the decoder

    // --------------------------------------------------
    //  hs settle window
    // --------------------------------------------------

    localparam int SETTLE_CNT_W = 6;

    // cycles the window stays open once termination drops
    localparam logic [SETTLE_CNT_W-1:0] HS_SETTLE_CYCLES = 6'd10;

    // --------------------------------------------------
    //  top level defaults
    // --------------------------------------------------

    localparam int NUM_LANES_DEFAULT   = 2;
    localparam int HEARTBEAT_W_DEFAULT = 25;   // msb toggles at a visible rate

endpackage

`default_nettype wire
